// ==== rtl/dma_defs.svh ====
`ifndef DMA_DEFS_SVH
`define DMA_DEFS_SVH

// Command queue
`define DMA_QUEUE_DEPTH 8

// Bus and register word width in bits
`define DMA_WORD_BITS 32

`define DMA_ADDR_STEP 4 // Bytes per word

// CPU register offsets
`define DMA_REG_SRC   2'd0 // Fill value or copy source
`define DMA_REG_DST   2'd1
`define DMA_REG_COUNT 2'd2 // Words minus one
`define DMA_REG_CTRL  2'd3 // Type on write, status on read

`endif

// ==== rtl/dma_pkg.sv ====
`include "dma_defs.svh"

package dma_pkg;

	typedef logic [`DMA_WORD_BITS-1:0] word_t;
	typedef logic [`DMA_WORD_BITS-1:0] count_t; // Words to move, minus one

	localparam int OP_BITS = 2;

	typedef enum logic [OP_BITS-1:0] {
		OP_FILL = 2'd1,
		OP_COPY = 2'd2
	} dma_op_t;

	// Command layout, high to low: op, value or source, destination, count
	localparam int CMD_COUNT_LSB = 0;
	localparam int CMD_DEST_LSB  = CMD_COUNT_LSB + `DMA_WORD_BITS;
	localparam int CMD_VALUE_LSB = CMD_DEST_LSB + `DMA_WORD_BITS;
	localparam int CMD_OP_LSB    = CMD_VALUE_LSB + `DMA_WORD_BITS;
	localparam int CMD_BITS      = CMD_OP_LSB + OP_BITS; // 98

	typedef logic [CMD_BITS-1:0] cmd_word_t;

	typedef enum logic [3:0] {
		IDLE         = 4'd0,
		POP          = 4'd1, // Head read in flight
		LOAD         = 4'd2,
		FILL_REQ     = 4'd3,
		FILL_WAIT    = 4'd4,
		COPY_RD_REQ  = 4'd5,
		COPY_RD_WAIT = 4'd6,
		COPY_WR_REQ  = 4'd7,
		COPY_WR_WAIT = 4'd8
	} engine_state_t;

endpackage

// ==== rtl/dma_cmd_fifo.sv ====
`timescale 1ns/10ps
`include "dma_defs.svh"

module dma_cmd_fifo #(
	parameter int DEPTH = `DMA_QUEUE_DEPTH
) (
	input  logic               i_clock,
	input  logic               i_reset,
	input  logic               i_push,
	input  dma_pkg::cmd_word_t i_push_data,
	input  logic               i_pop,
	output dma_pkg::cmd_word_t o_pop_data,
	output logic               o_full,
	output logic               o_empty
);
	localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_BITS = $clog2(DEPTH + 1);

	dma_pkg::cmd_word_t mem [DEPTH];

	logic [PTR_BITS-1:0] wr_ptr;
	logic [PTR_BITS-1:0] rd_ptr;
	logic [CNT_BITS-1:0] fill_count;
	logic                do_push;
	logic                do_pop;

	assign o_full  = (fill_count == CNT_BITS'(DEPTH));
	assign o_empty = (fill_count == '0);

	assign do_push = i_push && !o_full;
	assign do_pop  = i_pop && !o_empty;

	// Pointers and occupancy
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			fill_count <= '0;
		end else begin
			if (do_push)
				wr_ptr <= (wr_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10:   fill_count <= fill_count + 1'b1;
				2'b01:   fill_count <= fill_count - 1'b1;
				default: fill_count <= fill_count; // Both or neither
			endcase
		end
	end

	// Storage and head register
	always_ff @(posedge i_clock) begin
		if (do_push)
			mem[wr_ptr] <= i_push_data;
		if (do_pop)
			o_pop_data <= mem[rd_ptr]; // Valid the cycle after pop
	end

	// Register port must hold off CTRL writes while full
	a_no_push_full: assert property (
		@(posedge i_clock) disable iff (i_reset)
		i_push |-> !o_full
	) else $error("dma_cmd_fifo: push while full");

	// Engine only pops after seeing the queue non-empty
	a_no_pop_empty: assert property (
		@(posedge i_clock) disable iff (i_reset)
		i_pop |-> !o_empty
	) else $error("dma_cmd_fifo: pop while empty");

endmodule

// ==== rtl/dma_reg_if.sv ====
`timescale 1ns/10ps
`include "dma_defs.svh"

module dma_reg_if (
	input  logic               i_clock,
	input  logic               i_reset,
	input  logic               i_request,
	input  logic               i_rw,        // 1 = write
	input  logic [1:0]         i_address,
	input  dma_pkg::word_t     i_wdata,
	output dma_pkg::word_t     o_rdata,
	output logic               o_ready,
	input  logic               i_queue_full,
	input  logic               i_queue_empty,
	input  logic               i_engine_busy,
	output logic               o_push,
	output dma_pkg::cmd_word_t o_push_data
);
	dma_pkg::word_t   src_value; // Fill value or copy source
	dma_pkg::word_t   dst;
	dma_pkg::count_t  count;
	dma_pkg::dma_op_t op;
	logic             busy;

	assign busy = !i_queue_empty || i_engine_busy;

	// Command assembled from the held registers
	always_comb begin
		o_push_data = '0;
		o_push_data[dma_pkg::CMD_OP_LSB +: dma_pkg::OP_BITS]   = op;
		o_push_data[dma_pkg::CMD_VALUE_LSB +: `DMA_WORD_BITS]  = src_value;
		o_push_data[dma_pkg::CMD_DEST_LSB +: `DMA_WORD_BITS]   = dst;
		o_push_data[dma_pkg::CMD_COUNT_LSB +: `DMA_WORD_BITS]  = count;
	end

	// Handshake and queue push
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_ready <= 1'b0;
			o_push  <= 1'b0;
		end else begin
			o_push <= 1'b0;
			if (!i_request) begin
				o_ready <= 1'b0;
			end else if (!i_rw) begin
				o_ready <= 1'b1; // Reads never stall
			end else if (i_address == `DMA_REG_CTRL) begin
				// Stall until a slot frees, push only on the first ready cycle
				if (!i_queue_full) begin
					o_push  <= !o_ready;
					o_ready <= 1'b1;
				end
			end else begin
				o_ready <= 1'b1;
			end
		end
	end

	// Command registers and read data
	always_ff @(posedge i_clock) begin
		if (i_request && i_rw) begin
			case (i_address)
				`DMA_REG_SRC:   src_value <= i_wdata;
				`DMA_REG_DST:   dst <= i_wdata;
				`DMA_REG_COUNT: count <= i_wdata;
				`DMA_REG_CTRL:  op <= dma_pkg::dma_op_t'(i_wdata[dma_pkg::OP_BITS-1:0]);
				default:        op <= op;
			endcase
		end
		if (i_request && !i_rw) begin
			if (i_address == `DMA_REG_CTRL)
				o_rdata <= busy ? '1 : '0;
			else
				o_rdata <= '0;
		end
	end

endmodule

// ==== rtl/dma_engine.sv ====
`timescale 1ns/10ps
`include "dma_defs.svh"

module dma_engine (
	input  logic               i_clock,
	input  logic               i_reset,
	output logic               o_pop,
	input  dma_pkg::cmd_word_t i_cmd,
	input  logic               i_queue_empty,
	output logic               o_busy,
	output logic               o_bus_request,
	output logic               o_bus_rw,      // 1 = write
	output dma_pkg::word_t     o_bus_address,
	output dma_pkg::word_t     o_bus_wdata,
	input  logic               i_bus_ready,
	input  dma_pkg::word_t     i_bus_rdata
);
	localparam dma_pkg::word_t ADDR_STEP = dma_pkg::word_t'(`DMA_ADDR_STEP);

	dma_pkg::engine_state_t state;
	dma_pkg::dma_op_t       load_op;
	dma_pkg::word_t         src_value; // Fill value or read address
	dma_pkg::word_t         dst;
	dma_pkg::count_t        count;
	dma_pkg::word_t         copy_data;
	logic                   last_word;
	logic                   waiting;

	assign load_op   = dma_pkg::dma_op_t'(i_cmd[dma_pkg::CMD_OP_LSB +: dma_pkg::OP_BITS]);
	assign last_word = (count == '0);

	assign o_pop  = (state == dma_pkg::POP);
	assign o_busy = (state != dma_pkg::IDLE);

	assign waiting = (state == dma_pkg::FILL_WAIT) || (state == dma_pkg::COPY_RD_WAIT) ||
		(state == dma_pkg::COPY_WR_WAIT);

	// State and bus control
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state         <= dma_pkg::IDLE;
			o_bus_request <= 1'b0;
			o_bus_rw      <= 1'b0;
		end else begin
			case (state)
				dma_pkg::IDLE:
					if (!i_queue_empty)
						state <= dma_pkg::POP;
				dma_pkg::POP:
					state <= dma_pkg::LOAD; // Head lands in the fifo register
				dma_pkg::LOAD:
					case (load_op)
						dma_pkg::OP_FILL: state <= dma_pkg::FILL_REQ;
						dma_pkg::OP_COPY: state <= dma_pkg::COPY_RD_REQ;
						default:          state <= dma_pkg::IDLE; // Dropped
					endcase
				dma_pkg::FILL_REQ: begin
					o_bus_request <= 1'b1;
					o_bus_rw      <= 1'b1;
					state         <= dma_pkg::FILL_WAIT;
				end
				dma_pkg::FILL_WAIT:
					if (i_bus_ready) begin
						o_bus_request <= 1'b0;
						state <= last_word ? dma_pkg::IDLE : dma_pkg::FILL_REQ;
					end
				dma_pkg::COPY_RD_REQ: begin
					o_bus_request <= 1'b1;
					o_bus_rw      <= 1'b0;
					state         <= dma_pkg::COPY_RD_WAIT;
				end
				dma_pkg::COPY_RD_WAIT:
					if (i_bus_ready) begin
						o_bus_request <= 1'b0;
						state         <= dma_pkg::COPY_WR_REQ;
					end
				dma_pkg::COPY_WR_REQ: begin
					o_bus_request <= 1'b1;
					o_bus_rw      <= 1'b1;
					state         <= dma_pkg::COPY_WR_WAIT;
				end
				dma_pkg::COPY_WR_WAIT:
					if (i_bus_ready) begin
						o_bus_request <= 1'b0;
						state <= last_word ? dma_pkg::IDLE : dma_pkg::COPY_RD_REQ;
					end
				default:
					state <= dma_pkg::IDLE;
			endcase
		end
	end

	// Addresses, count and bus payload
	always_ff @(posedge i_clock) begin
		case (state)
			dma_pkg::LOAD: begin
				src_value <= i_cmd[dma_pkg::CMD_VALUE_LSB +: `DMA_WORD_BITS];
				dst       <= i_cmd[dma_pkg::CMD_DEST_LSB +: `DMA_WORD_BITS];
				count     <= i_cmd[dma_pkg::CMD_COUNT_LSB +: `DMA_WORD_BITS];
			end
			dma_pkg::FILL_REQ: begin
				o_bus_address <= dst;
				o_bus_wdata   <= src_value;
			end
			dma_pkg::COPY_RD_REQ:
				o_bus_address <= src_value;
			dma_pkg::COPY_RD_WAIT:
				if (i_bus_ready) begin
					copy_data <= i_bus_rdata; // Taken on the ready cycle
					src_value <= src_value + ADDR_STEP;
				end
			dma_pkg::COPY_WR_REQ: begin
				o_bus_address <= dst;
				o_bus_wdata   <= copy_data;
			end
			dma_pkg::FILL_WAIT, dma_pkg::COPY_WR_WAIT:
				if (i_bus_ready) begin
					dst <= dst + ADDR_STEP;
					if (!last_word)
						count <= count - 1'b1;
				end
			default: begin
			end
		endcase
	end

	// Memory side sees a steady request until it answers
	a_bus_stable: assert property (
		@(posedge i_clock) disable iff (i_reset)
		(waiting && !i_bus_ready) |=> (o_bus_request && $stable(o_bus_address) &&
			$stable(o_bus_rw) && $stable(o_bus_wdata))
	) else $error("dma_engine: bus request changed before ready");

endmodule

// ==== rtl/dma_top.sv ====
`timescale 1ns/10ps
`include "dma_defs.svh"

module dma_top (
	input  logic           i_clock,
	input  logic           i_reset,

	// CPU register port
	input  logic           i_request,
	input  logic           i_rw,
	input  logic [1:0]     i_address,
	input  dma_pkg::word_t i_wdata,
	output dma_pkg::word_t o_rdata,
	output logic           o_ready,

	// Memory bus
	output logic           o_bus_request,
	output logic           o_bus_rw,
	output dma_pkg::word_t o_bus_address,
	output dma_pkg::word_t o_bus_wdata,
	input  logic           i_bus_ready,
	input  dma_pkg::word_t i_bus_rdata
);
	logic               queue_push;
	dma_pkg::cmd_word_t queue_push_data;
	logic               queue_pop;
	dma_pkg::cmd_word_t queue_pop_data;
	logic               queue_full;
	logic               queue_empty;
	logic               engine_busy;

	dma_reg_if i_dma_reg_if (
		.i_clock       (i_clock),
		.i_reset       (i_reset),
		.i_request     (i_request),
		.i_rw          (i_rw),
		.i_address     (i_address),
		.i_wdata       (i_wdata),
		.o_rdata       (o_rdata),
		.o_ready       (o_ready),
		.i_queue_full  (queue_full),
		.i_queue_empty (queue_empty),
		.i_engine_busy (engine_busy),
		.o_push        (queue_push),
		.o_push_data   (queue_push_data)
	);

	dma_cmd_fifo #(
		.DEPTH(`DMA_QUEUE_DEPTH)
	) i_dma_cmd_fifo (
		.i_clock     (i_clock),
		.i_reset     (i_reset),
		.i_push      (queue_push),
		.i_push_data (queue_push_data),
		.i_pop       (queue_pop),
		.o_pop_data  (queue_pop_data),
		.o_full      (queue_full),
		.o_empty     (queue_empty)
	);

	dma_engine i_dma_engine (
		.i_clock       (i_clock),
		.i_reset       (i_reset),
		.o_pop         (queue_pop),
		.i_cmd         (queue_pop_data),
		.i_queue_empty (queue_empty),
		.o_busy        (engine_busy),
		.o_bus_request (o_bus_request),
		.o_bus_rw      (o_bus_rw),
		.o_bus_address (o_bus_address),
		.o_bus_wdata   (o_bus_wdata),
		.i_bus_ready   (i_bus_ready),
		.i_bus_rdata   (i_bus_rdata)
	);

endmodule

// ==== verif/tb_clock_gen.sv ====
`timescale 1ns/10ps

module tb_clock_gen #(
	parameter real PERIOD_NS    = 40.0,
	parameter int  RESET_CYCLES = 10
) (
	output logic o_clock,
	output logic o_reset
);
	initial begin
		o_clock = 1'b0;
		forever #(PERIOD_NS / 2.0) o_clock = ~o_clock;
	end

	// Reset released on a rising edge, like any other driven input
	initial begin
		o_reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge o_clock);
		o_reset <= 1'b0;
	end

endmodule

// ==== verif/tb_dma_top.sv ====
`timescale 1ns/10ps
`include "dma_defs.svh"

module tb_dma_top;
	localparam int             CYCLES_PER_LINE = 2000;
	localparam int             RESET_CYCLES    = 10;
	localparam dma_pkg::word_t READ_XOR        = 32'h5A5A0000; // Memory read data rule

	logic           clock;
	logic           reset;
	logic           request = 1'b0;
	logic           rw = 1'b0;
	logic [1:0]     address = 2'd0;
	dma_pkg::word_t wdata = '0;
	dma_pkg::word_t rdata;
	logic           ready;
	logic           bus_request;
	logic           bus_rw;
	dma_pkg::word_t bus_address;
	dma_pkg::word_t bus_wdata;
	logic           bus_ready = 1'b0;
	dma_pkg::word_t bus_rdata = '0;

	// Operations in file order, expected writes in bus order
	logic [7:0]     op_kind [$];
	logic [1:0]     op_offset [$];
	dma_pkg::word_t op_data [$]; // Write data, expected status or write target of an idle line
	dma_pkg::word_t exp_address [$];
	dma_pkg::word_t exp_data [$];
	int             stim_lines = 0;
	int             writes_seen = 0; // Bus writes matched so far
	logic           stim_loaded = 1'b0;
	logic [31:0]    rand_state = 32'h3421;

	tb_clock_gen #(
		.PERIOD_NS    (40.0),
		.RESET_CYCLES (RESET_CYCLES)
	) i_tb_clock_gen (
		.o_clock (clock),
		.o_reset (reset)
	);

	dma_top i_dma_top (
		.i_clock       (clock),
		.i_reset       (reset),
		.i_request     (request),
		.i_rw          (rw),
		.i_address     (address),
		.i_wdata       (wdata),
		.o_rdata       (rdata),
		.o_ready       (ready),
		.o_bus_request (bus_request),
		.o_bus_rw      (bus_rw),
		.o_bus_address (bus_address),
		.o_bus_wdata   (bus_wdata),
		.i_bus_ready   (bus_ready),
		.i_bus_rdata   (bus_rdata)
	);

	function automatic logic [31:0] next_random(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("=== FAIL ===");
		$fatal(1, "stopped at first error");
	endtask

	task automatic load_stimulus();
		int                  fd;
		int                  n;
		int                  words;
		int                  i;
		int                  total;
		int                  last_idle;
		logic [7:0]          kind;
		logic [8*200-1:0]    rest;
		dma_pkg::word_t      a;
		dma_pkg::word_t      b;
		total     = 0;
		last_idle = -1;
		fd = $fopen("verif/dma_stim.txt", "r");
		assert (fd != 0) else stop_on_error("cannot open verif/dma_stim.txt");
		while ($fscanf(fd, " %c", kind) == 1) begin
			if (kind == "#") begin
				n = $fgets(rest, fd); // Comment, skip the line
			end else if (kind == "E") begin
				n = $fscanf(fd, "%h %h %d", a, b, words);
				assert (n == 3) else stop_on_error("badly formed expected write line");
				for (i = 0; i < words; i++) begin
					exp_address.push_back(a + i * `DMA_ADDR_STEP);
					exp_data.push_back(b);
				end
				total += words;
				if (last_idle >= 0)
					op_data[last_idle] = total; // Writes listed after an idle line are due by it
				stim_lines++;
			end else begin
				a = '0;
				b = '0;
				if (kind == "W" || kind == "R") begin
					n = $fscanf(fd, "%h %h", a, b);
					assert (n == 2) else stop_on_error("badly formed register line");
					if (kind == "W")
						last_idle = -1; // Next command group starts
				end else begin
					assert (kind == "I") else stop_on_error("unknown line type in stimulus");
					b         = total;
					last_idle = op_kind.size();
				end
				op_kind.push_back(kind);
				op_offset.push_back(a[1:0]);
				op_data.push_back(b);
				stim_lines++;
			end
		end
		$fclose(fd);
	endtask

	// One CPU access, held until ready and then released
	task automatic cpu_access(input logic write, input logic [1:0] offset,
			input dma_pkg::word_t data, output dma_pkg::word_t read_value);
		@(posedge clock);
		request <= 1'b1;
		rw      <= write;
		address <= offset;
		wdata   <= data;
		do begin
			@(posedge clock);
		end while (!ready); // A full queue stalls CTRL writes here
		read_value = rdata;
		request <= 1'b0;
		do begin
			@(posedge clock);
		end while (ready);
	endtask

	task automatic wait_until_idle();
		dma_pkg::word_t status;
		status = '1;
		while (status !== '0) begin
			cpu_access(1'b0, `DMA_REG_CTRL, '0, status);
		end
	endtask

	// Idle once every write listed for the commands so far has been seen on the bus
	task automatic wait_for_writes(input int target);
		while (writes_seen < target)
			@(posedge clock);
	endtask

	task automatic check_bus_write(input dma_pkg::word_t addr, input dma_pkg::word_t data);
		dma_pkg::word_t want_addr;
		dma_pkg::word_t want_data;
		assert (exp_address.size() > 0) else
			stop_on_error($sformatf("unexpected bus write of %h to %h at %0t", data, addr, $time));
		want_addr = exp_address.pop_front();
		want_data = exp_data.pop_front();
		assert (addr === want_addr && data === want_data) else
			stop_on_error($sformatf("mismatch at %0t: bus write %h to %h, expected %h to %h",
				$time, data, addr, want_data, want_addr));
		writes_seen++;
	endtask

	// Memory: random latency, reads follow the XOR rule
	initial begin : memory_model
		int delay;
		forever begin
			@(posedge clock);
			if (!reset && bus_request) begin
				rand_state = next_random(rand_state);
				delay = rand_state % 6;
				repeat (delay) @(posedge clock);
				if (bus_rw)
					check_bus_write(bus_address, bus_wdata);
				bus_rdata <= bus_address ^ READ_XOR;
				bus_ready <= 1'b1;
				@(posedge clock);
				bus_ready <= 1'b0; // Request drops on this edge
			end
		end
	end

	initial begin : stimulus
		dma_pkg::word_t value;
		int             i;
		int             pending;
		load_stimulus();
		stim_loaded = 1'b1;
		wait (!reset);
		for (i = 0; i < op_kind.size(); i++) begin
			if (op_kind[i] == "W") begin
				cpu_access(1'b1, op_offset[i], op_data[i], value);
			end else if (op_kind[i] == "R") begin
				cpu_access(1'b0, op_offset[i], '0, value);
				assert (value === op_data[i]) else
					stop_on_error($sformatf("mismatch at %0t: offset %0d read %h, expected %h",
						$time, op_offset[i], value, op_data[i]));
			end else begin
				wait_for_writes(op_data[i]);
			end
		end
		wait_until_idle();
		pending = exp_address.size();
		assert (pending == 0) else
			$display("expected bus writes never seen: %0d left", pending);
		if (pending == 0) begin
			$display("=== PASS ===");
			$finish;
		end else begin
			$display("=== FAIL ===");
			$fatal(1, "missing bus writes");
		end
	end

	initial begin : watchdog
		wait (stim_loaded);
		repeat (RESET_CYCLES + stim_lines * CYCLES_PER_LINE) @(posedge clock);
		$display("watchdog expired, the DMA did not finish in time");
		$display("=== FAIL ===");
		$fatal(1, "timeout");
	end

endmodule

// ==== verif/dma_stim.txt ====
# W offset data | R offset expected | I wait until idle
# E address data words: expected writes of data at address, address+4, ... (hex, words decimal)
W 0 cafe0001
W 1 00001000
W 2 00000003
W 3 00000001
R 3 ffffffff
I
R 3 00000000
E 00001000 cafe0001 4
W 0 00002000
W 1 00003000
W 2 00000002
W 3 00000002
R 3 ffffffff
I
E 00003000 5a5a2000 1
E 00003004 5a5a2004 1
E 00003008 5a5a2008 1
W 3 00000000
W 3 00000003
W 0 0badf00d
W 2 00000000
W 3 00000001
I
R 3 00000000
E 00003000 0badf00d 1
W 0 11110000
W 1 00004000
W 2 0000001f
W 3 00000001
W 0 22220000
W 2 00000001
W 3 00000001
W 3 00000001
W 3 00000001
W 3 00000001
W 3 00000001
W 3 00000001
W 3 00000001
W 3 00000001
W 3 00000001
I
E 00004000 11110000 32
E 00004000 22220000 2
E 00004000 22220000 2
E 00004000 22220000 2
E 00004000 22220000 2
E 00004000 22220000 2
E 00004000 22220000 2
E 00004000 22220000 2
E 00004000 22220000 2
E 00004000 22220000 2

// ==== tb.f ====
+incdir+rtl
rtl/dma_pkg.sv
rtl/dma_cmd_fifo.sv
rtl/dma_reg_if.sv
rtl/dma_engine.sv
rtl/dma_top.sv
verif/tb_clock_gen.sv
verif/tb_dma_top.sv

// ==== Bender.yml ====
package:
  name: dma_subsystem

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/dma_pkg.sv
      - rtl/dma_cmd_fifo.sv
      - rtl/dma_reg_if.sv
      - rtl/dma_engine.sv
      - rtl/dma_top.sv

  - target: test
    include_dirs:
      - rtl
    files:
      - verif/tb_clock_gen.sv
      - verif/tb_dma_top.sv
